// File: bench/feature_input.txt
# R rcs snr spread md_peak md_period exp_md exp_conf exp_noise exp_deception (hex, Q15.16)
# I vx vy nis [rpt_spd_avg rpt_spd_peak rpt_nis_avg rpt_nis_peak rpt_ecm_score rpt_ecm_detected]
H 2 2
I 00030000 00000000 00020000
I 00000000 FFFD0000 00020000 00030000 00030000 00020000 00020000 00000000 0
R 00010000 00190000 00010000 00000000 00000000 0 0000E000 0 0
R 00010000 00190000 00010000 00080000 00008000 1 0000A000 0 0
R 00010000 00190000 00010000 00140000 00008000 3 0000C000 0 0
I FFFD0000 00000000 00020000
I 00030000 00000000 00020000 00030000 00030000 00020000 00020000 00000000 0
R 00010000 00190000 00010000 00640000 00008000 2 0000D000 0 0
R 00010000 00190000 00010000 00280000 00008000 5 0000B000 0 0
I 000A0000 00050000 00020000
I 00000000 00000000 00020000 00045995 000BFFFE 00020000 00020000 00000000 0
R 00010000 00190000 00010000 01F40000 00008000 7 00004000 0 0
R 00010000 00190000 00320000 00000000 00000000 7 00002000 0 0
I FFF90000 00000000 00020000
I 00020000 00000000 00020000 0004315C 000BFFFE 00020000 00020000 00000000 0
R 00010000 000A0000 07D00000 00000000 00000000 6 0000E000 1 0
R 00010000 000A0000 03200000 00000000 00000000 4 0000C000 1 0
I 00000000 00140000 00020000
I 00000000 00000000 003C0000 000648C1 00140000 00020000 00020000 00070000 1

// File: compile.f
source/feature_pkg.sv
source/rf_obs_if.sv
source/kinematic_stats.sv
source/micro_doppler_classifier.sv
source/ecm_detector.sv
source/feature_reporter.sv
source/feature_ext_top.sv
bench/feature_checker.sv
bench/tb_feature_ext.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the feature extractor testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_feature_ext -f compile.f -o sim_feature_ext
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_feature_ext > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$LOG"; then
    exit 0
else
    exit 1
fi

// File: bench/tb_feature_ext.sv
module tb_feature_ext
    import feature_pkg::*;
();

    localparam int REPORT_INTERVAL = 2;             // Must match the data file header
    localparam int BASELINE_LEN    = 2;
    localparam int WAIT_LIMIT      = 8;             // Cycles allowed for any wait

    logic                   clk, rst_n;
    logic                   imm_valid, rf_valid;
    logic signed [FP_W-1:0] vx, vy, nis_cv;
    logic signed [FP_W-1:0] rcs_amplitude, snr_db, doppler_spread_hz;
    logic signed [FP_W-1:0] micro_doppler_peak_hz, micro_doppler_period;
    logic                   report_valid, rpt_ecm_detected;
    logic                   ecm_noise_flag, ecm_deception_flag;
    logic signed [FP_W-1:0] rpt_spd_avg, rpt_spd_peak, rpt_nis_avg, rpt_nis_peak;
    logic signed [FP_W-1:0] rpt_md_conf, rpt_ecm_score;
    logic [MD_W-1:0]        rpt_md_type;

    string       line;
    int          fd, code, setup_errors, timeouts, wait_cycles, total;
    logic [7:0]  tag;
    logic [31:0] fld [0:8];                         // Fields after the record tag

    feature_ext_top #(.REPORT_INTERVAL(REPORT_INTERVAL), .BASELINE_LEN(BASELINE_LEN))
        i_feature_ext_top (.*);

    feature_checker #(.REPORT_INTERVAL(REPORT_INTERVAL)) i_checker (
        .clk, .rst_n, .imm_valid, .rf_valid, .report_valid, .rpt_spd_avg, .rpt_spd_peak,
        .rpt_nis_avg, .rpt_nis_peak, .rpt_md_type, .rpt_md_conf, .rpt_ecm_score,
        .rpt_ecm_detected, .ecm_noise_flag, .ecm_deception_flag);

    always #50 clk = ~clk;                          // Period 100

    // ========================================================================
    // Record drivers with one strobe cycle then one idle cycle
    // ========================================================================
    task drive_rf();
        @(posedge clk);
        #10;
        rcs_amplitude         = fld[0];
        snr_db                = fld[1];
        doppler_spread_hz     = fld[2];
        micro_doppler_peak_hz = fld[3];
        micro_doppler_period  = fld[4];
        rf_valid              = 1'b1;
        i_checker.expect_rf(fld[5][MD_W-1:0], fld[6], fld[7][0], fld[8][0]);
        @(posedge clk);
        #10;
        rf_valid              = 1'b0;
        rcs_amplitude         = '0;                 // Data words only valid with the strobe
        snr_db                = '0;
        doppler_spread_hz     = '0;
        micro_doppler_peak_hz = '0;
        micro_doppler_period  = '0;
    endtask

    task drive_imm(input logic with_report);
        @(posedge clk);
        #10;
        vx        = fld[0];
        vy        = fld[1];
        nis_cv    = fld[2];
        imm_valid = 1'b1;
        if (with_report)
            i_checker.expect_report(fld[3], fld[4], fld[5], fld[6], fld[7], fld[8][0]);
        @(posedge clk);
        #10 imm_valid = 1'b0;
        if (with_report) begin
            wait_cycles = 0;
            while (!report_valid && wait_cycles < WAIT_LIMIT) begin
                @(posedge clk);
                wait_cycles++;
            end
            if (!report_valid) begin
                timeouts++;
                $display("Timeout: report_valid did not rise after the report strobe");
            end
        end
    endtask

    task run_records();
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin   // Skip comments
                code = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h", tag, fld[0], fld[1],
                               fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
                case (tag)
                    "H": if (fld[0] != REPORT_INTERVAL || fld[1] != BASELINE_LEN) begin
                        setup_errors++;
                        $display("Data file expects REPORT_INTERVAL %0d, BASELINE_LEN %0d",
                                 fld[0], fld[1]);
                    end
                    "R": drive_rf();
                    "I": drive_imm(code == 10);     // Full line carries a report
                    default: begin
                        setup_errors++;
                        $display("Unknown record in data file: %s", line);
                    end
                endcase
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        imm_valid = 1'b0;
        rf_valid = 1'b0;
        vx = '0;
        vy = '0;
        nis_cv = '0;
        rcs_amplitude = '0;
        snr_db = '0;
        doppler_spread_hz = '0;
        micro_doppler_peak_hz = '0;
        micro_doppler_period = '0;
        setup_errors = 0;
        timeouts = 0;
        fd = $fopen("bench/feature_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/feature_input.txt");
            $display("Test failed");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            #10 rst_n = 1'b1;
            run_records();
            $fclose(fd);
            wait_cycles = 0;                        // Let the checker drain its queues
            while (i_checker.pending() != 0 && wait_cycles < WAIT_LIMIT) begin
                @(posedge clk);
                wait_cycles++;
            end
            if (i_checker.pending() != 0) begin
                timeouts++;
                $display("Timeout: %0d expected results never observed", i_checker.pending());
            end
            repeat (2) @(posedge clk);
            total = i_checker.error_count + setup_errors + timeouts;
            $display("Summary: %0d check errors, %0d setup errors, %0d timeouts, %0d reports",
                     i_checker.error_count, setup_errors, timeouts, i_checker.report_count);
            if (total == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

// File: bench/feature_checker.sv
module feature_checker
    import feature_pkg::*;
#(
    parameter int REPORT_INTERVAL = 10
) (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   imm_valid,
    input logic                   rf_valid,
    input logic                   report_valid,
    input logic signed [FP_W-1:0] rpt_spd_avg,
    input logic signed [FP_W-1:0] rpt_spd_peak,
    input logic signed [FP_W-1:0] rpt_nis_avg,
    input logic signed [FP_W-1:0] rpt_nis_peak,
    input logic [MD_W-1:0]        rpt_md_type,
    input logic signed [FP_W-1:0] rpt_md_conf,
    input logic signed [FP_W-1:0] rpt_ecm_score,
    input logic                   rpt_ecm_detected,
    input logic                   ecm_noise_flag,
    input logic                   ecm_deception_flag
);

    logic [MD_W+FP_W+1:0] rf_q [$];                 // {md, conf, noise, deception}
    logic [5*FP_W:0]      rpt_q [$];                // {avg, peak, nis avg, nis peak, score, det}
    logic [MD_W+FP_W+1:0] rf_entry;
    logic [MD_W-1:0]      exp_md;                   // Class of the latest RF record
    logic [FP_W-1:0]      exp_conf;
    logic                 exp_noise, exp_decep;
    logic                 rf_pending, rpt_due;
    int                   imm_cnt, error_count, report_count;

    initial begin
        error_count  = 0;
        report_count = 0;
        exp_md       = MD_UNKNOWN;                  // Classifier reset state
        exp_conf     = FP_ZERO;
        exp_noise    = 1'b0;
        exp_decep    = 1'b0;
    end

    task automatic expect_rf(input logic [MD_W-1:0] md, input logic [FP_W-1:0] conf,
                             input logic noise, input logic decep);
        rf_q.push_back({md, conf, noise, decep});
    endtask

    task automatic expect_report(input logic [FP_W-1:0] avg, input logic [FP_W-1:0] peak,
                                 input logic [FP_W-1:0] nis_avg, input logic [FP_W-1:0] nis_pk,
                                 input logic [FP_W-1:0] score, input logic det);
        rpt_q.push_back({avg, peak, nis_avg, nis_pk, score, det});
    endtask

    function automatic int pending();
        return rf_q.size() + rpt_q.size();
    endfunction

    task automatic compare_word(input string name, input logic [FP_W-1:0] got,
                                input logic [FP_W-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // ========================================================================
    // Report contents with md fields from the latest RF record
    // ========================================================================
    task automatic check_report();
        logic [5*FP_W:0] e;
        if (rpt_q.size() == 0) begin
            error_count++;
            $display("Report pulse arrived with no expected report queued");
        end else begin
            e = rpt_q.pop_front();
            report_count++;
            compare_word("rpt_spd_avg", rpt_spd_avg, e[5*FP_W -: FP_W]);
            compare_word("rpt_spd_peak", rpt_spd_peak, e[4*FP_W -: FP_W]);
            compare_word("rpt_nis_avg", rpt_nis_avg, e[3*FP_W -: FP_W]);
            compare_word("rpt_nis_peak", rpt_nis_peak, e[2*FP_W -: FP_W]);
            compare_word("rpt_ecm_score", rpt_ecm_score, e[FP_W -: FP_W]);
            compare_word("rpt_ecm_detected", FP_W'(rpt_ecm_detected), FP_W'(e[0]));
            compare_word("rpt_ecm_detected vs flags", FP_W'(rpt_ecm_detected),
                         FP_W'(exp_noise | exp_decep));
            compare_word("rpt_md_type", FP_W'(rpt_md_type), FP_W'(exp_md));
            compare_word("rpt_md_conf", rpt_md_conf, exp_conf);
        end
    endtask

    // Sampled mid-cycle away from the edges the bench drives on
    always @(negedge clk) begin
        if (!rst_n) begin
            imm_cnt    = 0;
            rpt_due    = 1'b0;
            rf_pending = 1'b0;
        end else begin
            compare_word("report_valid", FP_W'(report_valid), FP_W'(rpt_due));
            if (report_valid)
                check_report();
            if (rf_pending) begin                   // RF update took effect last edge
                if (rf_q.size() == 0) begin
                    error_count++;
                    $display("RF strobe seen with no expected result queued");
                end else begin
                    rf_entry = rf_q.pop_front();
                    {exp_md, exp_conf, exp_noise, exp_decep} = rf_entry;
                end
            end
            compare_word("ecm_noise_flag", FP_W'(ecm_noise_flag), FP_W'(exp_noise));
            compare_word("ecm_deception_flag", FP_W'(ecm_deception_flag), FP_W'(exp_decep));
            rf_pending = rf_valid;
            rpt_due    = 1'b0;
            if (imm_valid) begin                    // Last strobe of the interval
                if (imm_cnt == REPORT_INTERVAL - 1) begin
                    imm_cnt = 0;
                    rpt_due = 1'b1;
                end else begin
                    imm_cnt = imm_cnt + 1;
                end
            end
        end
    end

endmodule

// File: source/feature_ext_top.sv
module feature_ext_top
    import feature_pkg::*;
#(
    parameter int REPORT_INTERVAL = 10,
    parameter int BASELINE_LEN    = 20
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic signed [FP_W-1:0] vx,
    input  logic signed [FP_W-1:0] vy,
    input  logic signed [FP_W-1:0] nis_cv,
    input  logic                   imm_valid,
    input  logic signed [FP_W-1:0] rcs_amplitude,
    input  logic signed [FP_W-1:0] snr_db,
    input  logic signed [FP_W-1:0] doppler_spread_hz,
    input  logic signed [FP_W-1:0] micro_doppler_peak_hz,
    input  logic signed [FP_W-1:0] micro_doppler_period,
    input  logic                   rf_valid,
    output logic                   report_valid,
    output logic signed [FP_W-1:0] rpt_spd_avg,
    output logic signed [FP_W-1:0] rpt_spd_peak,
    output logic signed [FP_W-1:0] rpt_nis_avg,
    output logic signed [FP_W-1:0] rpt_nis_peak,
    output logic [MD_W-1:0]        rpt_md_type,
    output logic signed [FP_W-1:0] rpt_md_conf,
    output logic signed [FP_W-1:0] rpt_ecm_score,
    output logic                   rpt_ecm_detected,
    output logic                   ecm_noise_flag,
    output logic                   ecm_deception_flag
);

    logic signed [FP_W-1:0] spd_cur, spd_avg, spd_peak, nis_avg, nis_peak;
    logic [MD_W-1:0]        md_type;
    logic signed [FP_W-1:0] md_conf, ecm_score;

    // RF observables onto the shared bus
    rf_obs_if rf_bus ();
    assign rf_bus.rf_valid              = rf_valid;
    assign rf_bus.rcs_amplitude         = rcs_amplitude;
    assign rf_bus.snr_db                = snr_db;
    assign rf_bus.doppler_spread_hz     = doppler_spread_hz;
    assign rf_bus.micro_doppler_peak_hz = micro_doppler_peak_hz;
    assign rf_bus.micro_doppler_period  = micro_doppler_period;

    kinematic_stats i_kinematic_stats (.*);

    micro_doppler_classifier i_md_classifier (.clk, .rst_n, .rf(rf_bus.sink), .spd_cur,
        .md_type, .md_conf);

    ecm_detector #(.BASELINE_LEN(BASELINE_LEN)) i_ecm_detector (.clk, .rst_n,
        .rf(rf_bus.sink), .nis_cv, .ecm_noise_flag, .ecm_deception_flag, .ecm_score);

    feature_reporter #(.REPORT_INTERVAL(REPORT_INTERVAL)) i_feature_reporter (.*);

endmodule

// File: source/feature_reporter.sv
module feature_reporter
    import feature_pkg::*;
#(
    parameter int REPORT_INTERVAL = 10
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   imm_valid,
    input  logic signed [FP_W-1:0] spd_avg,
    input  logic signed [FP_W-1:0] spd_peak,
    input  logic signed [FP_W-1:0] nis_avg,
    input  logic signed [FP_W-1:0] nis_peak,
    input  logic [MD_W-1:0]        md_type,
    input  logic signed [FP_W-1:0] md_conf,
    input  logic signed [FP_W-1:0] ecm_score,
    input  logic                   ecm_noise_flag,
    input  logic                   ecm_deception_flag,
    output logic                   report_valid,
    output logic signed [FP_W-1:0] rpt_spd_avg,
    output logic signed [FP_W-1:0] rpt_spd_peak,
    output logic signed [FP_W-1:0] rpt_nis_avg,
    output logic signed [FP_W-1:0] rpt_nis_peak,
    output logic [MD_W-1:0]        rpt_md_type,
    output logic signed [FP_W-1:0] rpt_md_conf,
    output logic signed [FP_W-1:0] rpt_ecm_score,
    output logic                   rpt_ecm_detected
);

    localparam int CNT_W = $clog2(REPORT_INTERVAL + 1);

    logic [CNT_W-1:0] sample_cnt;
    logic             last_sample;      // Strobe closing the interval

    assign last_sample = imm_valid && (sample_cnt == CNT_W'(REPORT_INTERVAL - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_cnt   <= '0;
            report_valid <= 1'b0;
        end else begin
            report_valid <= last_sample;                // One cycle pulse
            if (last_sample)
                sample_cnt <= '0;
            else if (imm_valid)
                sample_cnt <= sample_cnt + 1'b1;
        end
    end

    // Report snapshot, values from before this sample's update
    always_ff @(posedge clk) begin
        if (last_sample) begin
            rpt_spd_avg      <= spd_avg;
            rpt_spd_peak     <= spd_peak;
            rpt_nis_avg      <= nis_avg;
            rpt_nis_peak     <= nis_peak;
            rpt_md_type      <= md_type;
            rpt_md_conf      <= md_conf;
            rpt_ecm_score    <= ecm_score;
            rpt_ecm_detected <= ecm_noise_flag | ecm_deception_flag;
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        report_valid |=> !report_valid);

endmodule

// File: source/ecm_detector.sv
module ecm_detector
    import feature_pkg::*;
#(
    parameter int BASELINE_LEN = 20
) (
    input  logic                   clk,
    input  logic                   rst_n,
    rf_obs_if.sink                 rf,
    input  logic signed [FP_W-1:0] nis_cv,
    output logic                   ecm_noise_flag,
    output logic                   ecm_deception_flag,
    output logic signed [FP_W-1:0] ecm_score
);

    localparam int CNT_W = $clog2(BASELINE_LEN + 1);

    logic [CNT_W-1:0]       baseline_count;
    logic                   baseline_established;
    logic signed [FP_W-1:0] snr_base;       // Slow EMA frozen once learned
    logic signed [FP_W-1:0] snr_last;       // SNR of the latest RF sample
    logic signed [FP_W-1:0] rcs_base;
    logic signed [FP_W-1:0] rcs_dev_avg;    // Fast EMA of |rcs - rcs_base|
    logic signed [FP_W-1:0] spread_avg;
    logic                   snr_drop, rcs_dev, spread_hi, nis_hi;

    // ==========================================================================
    // Baseline learning and running averages
    // ==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baseline_count       <= '0;
            baseline_established <= 1'b0;
            snr_base             <= SNR_DEFAULT;
            snr_last             <= SNR_DEFAULT;
            rcs_base             <= FP_ONE;
            rcs_dev_avg          <= FP_ZERO;
            spread_avg           <= FP_ZERO;
        end else if (rf.rf_valid) begin
            if (!baseline_established) begin
                snr_base <= fp_mul(ONE_SLOW, snr_base) + fp_mul(ALPHA_SLOW, rf.snr_db);
                rcs_base <= fp_mul(ONE_SLOW, rcs_base) + fp_mul(ALPHA_SLOW, rf.rcs_amplitude);
                if (baseline_count == CNT_W'(BASELINE_LEN))
                    baseline_established <= 1'b1;       // After BASELINE_LEN+1 strobes
                else
                    baseline_count <= baseline_count + 1'b1;
            end
            snr_last    <= rf.snr_db;
            rcs_dev_avg <= fp_mul(ONE_FAST, rcs_dev_avg)
                         + fp_mul(ALPHA_FAST, fp_abs(rf.rcs_amplitude - rcs_base));
            spread_avg  <= fp_mul(ONE_FAST, spread_avg)
                         + fp_mul(ALPHA_FAST, rf.doppler_spread_hz);
        end
    end

    // Individual indicators gated by the learned baseline
    assign snr_drop  = baseline_established && ((snr_base - snr_last) > SNR_DROP_THR);
    assign rcs_dev   = baseline_established && (rcs_dev_avg > fp_mul(RCS_DEV_FACT, rcs_base));
    assign spread_hi = baseline_established && (spread_avg > SPREAD_THR);
    assign nis_hi    = baseline_established && (nis_cv > NIS_SPIKE);   // Track corruption

    assign ecm_noise_flag     = snr_drop && spread_hi;    // Barrage noise jamming
    assign ecm_deception_flag = rcs_dev;                  // RGPO, VGPO, DRFM

    always_comb begin
        ecm_score = FP_ZERO;
        if (snr_drop)  ecm_score = ecm_score + W_SNR_DROP;
        if (rcs_dev)   ecm_score = ecm_score + W_RCS_DEV;
        if (spread_hi) ecm_score = ecm_score + W_SPREAD;
        if (nis_hi)    ecm_score = ecm_score + W_NIS;
    end

    // Flags only once learning has fully completed and the counter is parked
    a_flags_after_baseline: assert property (@(posedge clk) disable iff (!rst_n)
        (ecm_noise_flag || ecm_deception_flag)
            |-> baseline_established && (baseline_count == CNT_W'(BASELINE_LEN)));

endmodule

// File: source/micro_doppler_classifier.sv
module micro_doppler_classifier
    import feature_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    rf_obs_if.sink                 rf,
    input  logic signed [FP_W-1:0] spd_cur,
    output logic [MD_W-1:0]        md_type,
    output logic signed [FP_W-1:0] md_conf
);

    // Fixed confidence per class
    localparam logic signed [FP_W-1:0] CONF_0875 = 32'sh0000_E000;
    localparam logic signed [FP_W-1:0] CONF_0813 = 32'sh0000_D000;
    localparam logic signed [FP_W-1:0] CONF_0750 = 32'sh0000_C000;
    localparam logic signed [FP_W-1:0] CONF_0688 = 32'sh0000_B000;
    localparam logic signed [FP_W-1:0] CONF_0625 = 32'sh0000_A000;
    localparam logic signed [FP_W-1:0] CONF_0250 = 32'sh0000_4000;
    localparam logic signed [FP_W-1:0] CONF_0125 = 32'sh0000_2000;

    logic signed [FP_W-1:0] spread, peak, period;

    // Inclusive band test on the micro-Doppler peak
    function automatic logic in_band(
        input logic signed [FP_W-1:0] f,
        input logic signed [FP_W-1:0] lo,
        input logic signed [FP_W-1:0] hi
    );
        return (f >= lo) && (f <= hi);
    endfunction

    assign spread = rf.doppler_spread_hz;
    assign peak   = rf.micro_doppler_peak_hz;
    assign period = rf.micro_doppler_period;

    // Decision tree, first match wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            md_type <= MD_UNKNOWN;
            md_conf <= FP_ZERO;
        end else if (rf.rf_valid) begin
            if (spread > MD_SPREAD_PLSM) begin                          // Broadband ionization
                md_type <= MD_PLASMA;        md_conf <= CONF_0875;
            end else if (spread > MD_SPREAD_JET && period < PERIODIC_THR) begin
                md_type <= MD_JET_TURBINE;   md_conf <= CONF_0750;
            end else if (period > PERIODIC_THR) begin                   // Periodic, by band
                if (in_band(peak, MD_MROTOR_LO, MD_MROTOR_HI)) begin
                    md_type <= MD_MULTI_ROTOR; md_conf <= CONF_0813;
                end else if (in_band(peak, MD_PROP_LO, MD_PROP_HI)) begin
                    md_type <= MD_PROPELLER;   md_conf <= CONF_0688;
                end else if (in_band(peak, MD_ROTOR_LO, MD_ROTOR_HI)) begin
                    md_type <= MD_ROTOR_BLADE; md_conf <= CONF_0750;
                end else if (in_band(peak, MD_FLAP_LO, MD_FLAP_HI)) begin
                    md_type <= MD_FLAPPING;    md_conf <= CONF_0625;
                end else begin
                    md_type <= MD_UNKNOWN;     md_conf <= CONF_0250;
                end
            end else if (spread < MD_SPREAD_STAT && spd_cur < MD_SPD_STAT) begin
                md_type <= MD_NONE;          md_conf <= CONF_0875;      // Stationary target
            end else begin
                md_type <= MD_UNKNOWN;       md_conf <= CONF_0125;
            end
        end
    end

    a_conf_range: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rf.rf_valid) |-> (md_conf <= FP_ONE) && (md_conf > FP_ZERO));

endmodule

// File: source/kinematic_stats.sv
module kinematic_stats
    import feature_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   imm_valid,
    input  logic signed [FP_W-1:0] vx,
    input  logic signed [FP_W-1:0] vy,
    input  logic signed [FP_W-1:0] nis_cv,
    output logic signed [FP_W-1:0] spd_cur,     // Speed of latest sample
    output logic signed [FP_W-1:0] spd_avg,
    output logic signed [FP_W-1:0] spd_peak,
    output logic signed [FP_W-1:0] nis_avg,
    output logic signed [FP_W-1:0] nis_peak
);

    logic signed [FP_W-1:0] avx, avy;
    logic signed [FP_W-1:0] spd_now;            // Speed of the strobed sample
    logic                   initialized;

    // Alpha-max-beta-min, max + 0.4*min
    assign avx     = fp_abs(vx);
    assign avy     = fp_abs(vy);
    assign spd_now = (avx > avy) ? avx + fp_mul(BETA_MIN, avy)
                                 : avy + fp_mul(BETA_MIN, avx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spd_cur     <= FP_ZERO;
            spd_avg     <= FP_ZERO;
            spd_peak    <= FP_ZERO;
            nis_avg     <= FP_ZERO;
            nis_peak    <= FP_ZERO;
            initialized <= 1'b0;
        end else if (imm_valid) begin
            spd_cur     <= spd_now;
            initialized <= 1'b1;
            if (!initialized) begin             // First sample seeds the averages
                spd_avg <= spd_now;
                nis_avg <= nis_cv;
            end else begin
                spd_avg <= fp_mul(ONE_FAST, spd_avg) + fp_mul(ALPHA_FAST, spd_now);
                nis_avg <= fp_mul(ONE_FAST, nis_avg) + fp_mul(ALPHA_FAST, nis_cv);
            end
            if (spd_now > spd_peak) spd_peak <= spd_now;    // Lifetime peaks
            if (nis_cv > nis_peak) nis_peak <= nis_cv;
        end
    end

    a_peak_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        spd_peak >= $past(spd_peak));

endmodule

// File: source/rf_obs_if.sv
interface rf_obs_if
    import feature_pkg::*;
();
    logic                   rf_valid;               // One-cycle strobe
    logic signed [FP_W-1:0] rcs_amplitude;          // Linear RCS, m^2
    logic signed [FP_W-1:0] snr_db;
    logic signed [FP_W-1:0] doppler_spread_hz;
    logic signed [FP_W-1:0] micro_doppler_peak_hz;  // Strongest uD line
    logic signed [FP_W-1:0] micro_doppler_period;   // 0 means aperiodic

    modport src (
        output rf_valid, rcs_amplitude, snr_db, doppler_spread_hz,
               micro_doppler_peak_hz, micro_doppler_period
    );
    modport sink (
        input  rf_valid, rcs_amplitude, snr_db, doppler_spread_hz,
               micro_doppler_peak_hz, micro_doppler_period
    );
endinterface

// File: source/feature_pkg.sv
package feature_pkg;

    // ==========================================================================
    // Fixed point format, signed Q15.16
    // ==========================================================================
    localparam int FP_W    = 32;
    localparam int FP_FRAC = 16;                            // Fraction bits

    localparam logic signed [FP_W-1:0] FP_ONE  = 32'sh0001_0000;
    localparam logic signed [FP_W-1:0] FP_ZERO = 32'sh0000_0000;

    // Full product, rescaled by an arithmetic shift, truncating
    function automatic logic signed [FP_W-1:0] fp_mul(
        input logic signed [FP_W-1:0] a,
        input logic signed [FP_W-1:0] b
    );
        logic signed [2*FP_W-1:0] prod;
        prod = a * b;
        return prod[FP_FRAC +: FP_W];
    endfunction

    function automatic logic signed [FP_W-1:0] fp_abs(input logic signed [FP_W-1:0] a);
        return a[FP_W-1] ? -a : a;
    endfunction

    // EMA weights and speed estimate weight
    localparam logic signed [FP_W-1:0] ALPHA_FAST = 32'sh0000_2666;   // 0.15
    localparam logic signed [FP_W-1:0] ONE_FAST   = 32'sh0000_D99A;   // 0.85
    localparam logic signed [FP_W-1:0] ALPHA_SLOW = 32'sh0000_0CCD;   // 0.05
    localparam logic signed [FP_W-1:0] ONE_SLOW   = 32'sh0000_F333;   // 0.95
    localparam logic signed [FP_W-1:0] BETA_MIN   = 32'sh0000_6666;   // 0.4 on min component

    // ==========================================================================
    // Micro-Doppler class codes and decision thresholds
    // ==========================================================================
    localparam int MD_W = 3;
    localparam logic [MD_W-1:0] MD_NONE        = 3'd0;    // Static, ground
    localparam logic [MD_W-1:0] MD_FLAPPING    = 3'd1;    // Birds
    localparam logic [MD_W-1:0] MD_MULTI_ROTOR = 3'd2;    // Drones
    localparam logic [MD_W-1:0] MD_ROTOR_BLADE = 3'd3;    // Helicopter
    localparam logic [MD_W-1:0] MD_JET_TURBINE = 3'd4;
    localparam logic [MD_W-1:0] MD_PROPELLER   = 3'd5;
    localparam logic [MD_W-1:0] MD_PLASMA      = 3'd6;    // Hypersonic sheath
    localparam logic [MD_W-1:0] MD_UNKNOWN     = 3'd7;

    localparam logic signed [FP_W-1:0] MD_FLAP_LO     = 32'sh0002_0000;  // 2 Hz
    localparam logic signed [FP_W-1:0] MD_FLAP_HI     = 32'sh000F_0000;  // 15 Hz
    localparam logic signed [FP_W-1:0] MD_ROTOR_LO    = 32'sh000A_0000;  // 10 Hz
    localparam logic signed [FP_W-1:0] MD_ROTOR_HI    = 32'sh0032_0000;  // 50 Hz
    localparam logic signed [FP_W-1:0] MD_MROTOR_LO   = 32'sh0032_0000;  // 50 Hz
    localparam logic signed [FP_W-1:0] MD_MROTOR_HI   = 32'sh012C_0000;  // 300 Hz
    localparam logic signed [FP_W-1:0] MD_PROP_LO     = 32'sh001E_0000;  // 30 Hz
    localparam logic signed [FP_W-1:0] MD_PROP_HI     = 32'sh0064_0000;  // 100 Hz
    localparam logic signed [FP_W-1:0] MD_SPREAD_JET  = 32'sh00C8_0000;  // 200 Hz
    localparam logic signed [FP_W-1:0] MD_SPREAD_PLSM = 32'sh03E8_0000;  // 1000 Hz
    localparam logic signed [FP_W-1:0] MD_SPREAD_STAT = 32'sh0005_0000;  // 5 Hz
    localparam logic signed [FP_W-1:0] MD_SPD_STAT    = 32'sh0005_0000;  // 5 m/s
    localparam logic signed [FP_W-1:0] PERIODIC_THR   = 32'sh0000_4000;  // 0.25

    // ==========================================================================
    // ECM thresholds and score weights
    // ==========================================================================
    localparam logic signed [FP_W-1:0] SNR_DROP_THR = 32'sh000A_0000;    // 10 dB
    localparam logic signed [FP_W-1:0] RCS_DEV_FACT = 32'sh0005_0000;    // 5x baseline
    localparam logic signed [FP_W-1:0] SPREAD_THR   = 32'sh0064_0000;    // 100 Hz
    localparam logic signed [FP_W-1:0] NIS_SPIKE    = 32'sh0032_0000;    // 50
    localparam logic signed [FP_W-1:0] W_SNR_DROP   = 32'sh0003_0000;    // 3.0
    localparam logic signed [FP_W-1:0] W_RCS_DEV    = 32'sh0002_0000;    // 2.0
    localparam logic signed [FP_W-1:0] W_SPREAD     = 32'sh0002_8000;    // 2.5
    localparam logic signed [FP_W-1:0] W_NIS        = 32'sh0001_8000;    // 1.5
    localparam logic signed [FP_W-1:0] SNR_DEFAULT  = 32'sh0019_0000;    // 25 dB

endpackage
